// ==== src.f ====
logic/dynaq_state_pkg.sv
logic/dynaq_io_pkg.sv
logic/training_sequencer.sv
logic/datapath_strobe_decoder.sv
logic/dynaq_training_controller.sv
tb/dynaq_controller_asserts.sv
tb/tb_dynaq_training_controller.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f \
    --top-module tb_dynaq_training_controller -o sim_tb \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

// ==== tb/tb_dynaq_training_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dynaq_training_controller
    import dynaq_state_pkg::*;
    import dynaq_io_pkg::*;
();

    logic               clk = 1'b0;
    logic               reset, start, next, completed, done;
    logic               remember_done, tx_done, remember_en;
    logic [STATE_W-1:0] current_state;
    datapath_strobes_t  observed;     // DUT outputs gathered in struct order
    logic               exp_freeze;

    always #4 clk = ~clk;

    dynaq_training_controller u_dynaq_training_controller (
        .clk                          (clk),
        .reset                        (reset),
        .start                        (start),
        .next                         (next),
        .completed                    (completed),
        .done                         (done),
        .remember_done                (remember_done),
        .tx_done                      (tx_done),
        .remember_en                  (remember_en),
        .w_history_table_enable       (observed.history_table),
        .w_history_table_enable_2     (observed.history_table_2),
        .update_episode_enable        (observed.update_episode),
        .w_g_register_enable          (observed.g_register),
        .w_max_register_enable        (observed.max_register),
        .w_reward_register_enable     (observed.reward_register),
        .w_qvalue_enable              (observed.qvalue),
        .w_step_count_enable          (observed.step_count),
        .w_action_register_enable     (observed.action_register),
        .w_curent_location_enable     (observed.current_location),
        .w_next_location_enable       (observed.next_location),
        .w_temp_next_location_enable  (observed.temp_next_location),
        .w_epsilon_register_enable    (observed.epsilon_register),
        .w_epsilon_threshhold_enable  (observed.epsilon_threshold),
        .remember_mode                (observed.remember_mode),
        .naddr_enviroment_register_en (observed.naddr_environment),
        .w_curent_location_select     (observed.current_location_select),
        .w_g_register_select          (observed.g_register_select),
        .w_step_count_select          (observed.step_count_select),
        .equal_select                 (observed.equal_select),
        .w_qtable_en                  (observed.w_qtable_en),
        .tx_dv                        (observed.tx_dv),
        .tx_sel                       (observed.tx_sel),
        .tx_data                      (observed.tx_data),
        .current_state                (current_state)
    );

    // Decoder state and strobes as seen inside the top
    bind dynaq_training_controller dynaq_controller_asserts u_controller_asserts (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .step_freeze (step_freeze),
        .strobes     (strobes)
    );

    // Reference outputs per state, written as membership lists
    function automatic datapath_strobes_t expected_strobes(input train_state_t s,
                                                           input logic freeze, input logic comp);
        datapath_strobes_t e;
        logic              tail;   // S10, S11 and the step end / report group
        tail = s inside {ST_S10, ST_S11, ST_S15, ST_S16, ST_S17, ST_S18};
        e = '0;
        e.update_episode     = (s == ST_INIT);
        e.history_table      = s inside {ST_INIT, ST_S14, ST_S15};
        e.history_table_2    = s inside {ST_INIT, ST_S9};
        e.g_register         = s inside {ST_S6, ST_S7, ST_S12, ST_S13};
        e.max_register       = s inside {ST_S5, ST_S11};
        e.reward_register    = (s == ST_S3);
        e.qvalue             = s inside {ST_S1, ST_S4, ST_S10};
        e.step_count         = !freeze && (s inside {ST_INIT, ST_S2});
        e.action_register    = (s == ST_S2);
        e.current_location   = (s inside {ST_INIT, ST_S8, ST_S15}) || (s == ST_S1 && comp);
        e.next_location      = s inside {ST_INIT, ST_S3};
        e.temp_next_location = (s inside {ST_INIT, ST_S7}) || (s == ST_S4 && comp);
        e.epsilon_register   = (s == ST_S2);
        e.epsilon_threshold  = (s == ST_S4) && !comp;
        e.remember_mode      = s inside {ST_S9, ST_S10, ST_S13, ST_S14};
        e.naddr_environment  = (s == ST_S3);
        e.current_location_select = tail || (s inside {ST_S1, ST_S2, ST_S3, ST_S4,
                                                       ST_S7, ST_S8, ST_S9, ST_S13, ST_S14});
        e.g_register_select  = s inside {ST_S7, ST_S13, ST_S14};
        e.step_count_select  = tail || (s == ST_S2);
        e.equal_select       = tail || (s inside {ST_S1, ST_S2, ST_S5, ST_S6,
                                                  ST_S8, ST_S9, ST_S12, ST_S13});
        e.w_qtable_en        = s inside {ST_S8, ST_S14, ST_S15};
        e.tx_dv              = s inside {ST_S16, ST_S17, ST_S18};
        e.tx_sel             = s inside {ST_S17, ST_S18};
        e.tx_data            = (s == ST_S17) ? TX_CODE_DONE : TX_CODE_REPORT;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic check_cycle(input string name, input train_state_t s);
        check_value({name, " state"}, 32'(s), 32'(current_state));
        check_value({name, " outputs"}, 32'(expected_strobes(s, exp_freeze, completed)),
                    32'(observed));
    endtask

    // One state per cycle, sampled mid-cycle
    task automatic expect_path(input string name, input train_state_t path[$]);
        foreach (path[i]) begin
            @(negedge clk);
            check_cycle(name, path[i]);
        end
    endtask

    task automatic wait_state(input string name, input train_state_t s, input int limit);
        int n;
        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (current_state === s) break;
        end
        if (n == limit) begin
            $display("%s timed out waiting for state %0d", name, s);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout in %s", name);
        end
        check_cycle(name, s);
    endtask

    task automatic pulse_tx_done();
        @(posedge clk) tx_done <= 1'b1;
        @(posedge clk) tx_done <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk) reset <= 1'b0;
        exp_freeze = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic test_reset();
        apply_reset();
        repeat (3) begin
            @(negedge clk);
            check_cycle("reset", ST_DECISION);
        end
    endtask

    task automatic test_plain_step();
        @(posedge clk) start <= 1'b1;
        wait_state("plain step", ST_INIT, 4);
        @(posedge clk) start <= 1'b0;
        expect_path("plain step", '{ST_S1, ST_S2, ST_S3, ST_S4, ST_S5, ST_S6, ST_S7,
                                    ST_S15, ST_S1});
    endtask

    task automatic test_replay();
        @(posedge clk) remember_en <= 1'b1;   // Seen in S7
        expect_path("replay", '{ST_S2, ST_S3, ST_S4, ST_S5, ST_S6, ST_S7, ST_S8});
        @(posedge clk) remember_en <= 1'b0;
        expect_path("replay", '{ST_S9, ST_S10, ST_S11, ST_S12, ST_S13, ST_S14, ST_S1});
    endtask

    task automatic test_episode_end();
        @(posedge clk) done <= 1'b1;          // Seen in S2
        expect_path("episode end", '{ST_S2, ST_INIT});
        @(posedge clk) done <= 1'b0;
        expect_path("episode end", '{ST_S1, ST_S2, ST_S3, ST_S4, ST_S5, ST_S6, ST_S7});
        @(posedge clk) done <= 1'b1;          // Seen in S15 only
        expect_path("episode end", '{ST_S15, ST_S1});
        check_value("done flag load", 32'd1,
                    32'(u_dynaq_training_controller.u_training_sequencer.done_flag));
        @(posedge clk) done <= 1'b0;
        // S4 clears the flag before S15 reads it again
        expect_path("episode end", '{ST_S2, ST_S3, ST_S4, ST_S5});
        check_value("done flag clear", 32'd0,
                    32'(u_dynaq_training_controller.u_training_sequencer.done_flag));
        expect_path("episode end", '{ST_S6, ST_S7, ST_S15, ST_S1});
    endtask

    task automatic test_report();
        @(posedge clk) begin
            completed <= 1'b1;
            next      <= 1'b1;
        end
        expect_path("report", '{ST_S2, ST_S3, ST_S4, ST_S16, ST_S16});
        check_value("report byte 1", 32'(TX_CODE_REPORT), 32'(observed.tx_data));
        pulse_tx_done();
        wait_state("report", ST_S17, 4);
        check_value("report byte 2", 32'(TX_CODE_DONE), 32'(observed.tx_data));
        pulse_tx_done();
        wait_state("report", ST_S18, 4);
        check_value("report byte 3", 32'(TX_CODE_REPORT), 32'(observed.tx_data));
        pulse_tx_done();
        wait_state("report", ST_S1, 4);       // Flag clear, back to action choice
    endtask

    task automatic test_freeze();
        apply_reset();                        // completed and next still high
        @(negedge clk);
        check_cycle("freeze", ST_DECISION);
        @(posedge clk) next <= 1'b0;
        exp_freeze = 1'b1;
        wait_state("freeze", ST_INIT, 4);
        check_value("freeze step_count", 32'd0, 32'(observed.step_count));
        expect_path("freeze", '{ST_S1, ST_S1});   // S1 holds while next is low
        @(posedge clk) next <= 1'b1;
        expect_path("freeze", '{ST_S1, ST_S2, ST_S3, ST_S4, ST_S16});
    endtask

    initial begin
        reset         = 1'b0;
        start         = 1'b0;
        next          = 1'b0;
        completed     = 1'b0;
        done          = 1'b0;
        remember_done = 1'b0;
        tx_done       = 1'b0;
        remember_en   = 1'b0;
        exp_freeze    = 1'b0;

        test_reset();
        test_plain_step();
        test_replay();
        test_episode_end();
        test_report();
        test_freeze();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/dynaq_controller_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module dynaq_controller_asserts
    import dynaq_state_pkg::*;
    import dynaq_io_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input train_state_t      state,
    input logic              step_freeze,
    input datapath_strobes_t strobes
);

    // Codes above ST_DECISION are never used
    state_legal: assert property (@(posedge clk) disable iff (!reset)
        32'(state) < NUM_STATES)
        else $error("state code %0d out of range", state);

    tx_sel_needs_dv: assert property (@(posedge clk) disable iff (!reset)
        strobes.tx_sel |-> strobes.tx_dv)
        else $error("tx_sel high without tx_dv");

    frozen_step_count: assert property (@(posedge clk) disable iff (!reset)
        step_freeze |-> !strobes.step_count)   // Counter stays put once frozen
        else $error("step_count enable high while frozen");

endmodule

`default_nettype wire

// ==== logic/dynaq_training_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dynaq_training_controller
    import dynaq_state_pkg::*;
    import dynaq_io_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 next,
    input  logic                 completed,
    input  logic                 done,
    input  logic                 remember_done,   // Kept for pin compatibility
    input  logic                 tx_done,
    input  logic                 remember_en,
    output logic                 w_history_table_enable,
    output logic                 w_history_table_enable_2,
    output logic                 update_episode_enable,
    output logic                 w_g_register_enable,
    output logic                 w_max_register_enable,
    output logic                 w_reward_register_enable,
    output logic                 w_qvalue_enable,
    output logic                 w_step_count_enable,
    output logic                 w_action_register_enable,
    output logic                 w_curent_location_enable,
    output logic                 w_next_location_enable,
    output logic                 w_temp_next_location_enable,
    output logic                 w_epsilon_register_enable,
    output logic                 w_epsilon_threshhold_enable,
    output logic                 remember_mode,
    output logic                 naddr_enviroment_register_en,
    output logic                 w_curent_location_select,
    output logic                 w_g_register_select,
    output logic                 w_step_count_select,
    output logic                 equal_select,
    output logic                 w_qtable_en,
    output logic                 tx_dv,
    output logic                 tx_sel,
    output logic [TX_BYTE_W-1:0] tx_data,
    output logic [STATE_W-1:0]   current_state
);

    train_state_t      state;
    logic              step_freeze;
    datapath_strobes_t strobes;

    training_sequencer u_training_sequencer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .next        (next),
        .completed   (completed),
        .done        (done),
        .remember_en (remember_en),
        .tx_done     (tx_done),
        .state       (state),
        .step_freeze (step_freeze)
    );

    datapath_strobe_decoder u_datapath_strobe_decoder (
        .state       (state),
        .step_freeze (step_freeze),
        .completed   (completed),
        .strobes     (strobes)
    );

    assign current_state = state;

    // Pin names follow the existing datapath, spelling included
    assign update_episode_enable        = strobes.update_episode;
    assign w_history_table_enable       = strobes.history_table;
    assign w_history_table_enable_2     = strobes.history_table_2;
    assign w_g_register_enable          = strobes.g_register;
    assign w_max_register_enable        = strobes.max_register;
    assign w_reward_register_enable     = strobes.reward_register;
    assign w_qvalue_enable              = strobes.qvalue;
    assign w_step_count_enable          = strobes.step_count;
    assign w_action_register_enable     = strobes.action_register;
    assign w_curent_location_enable     = strobes.current_location;
    assign w_next_location_enable       = strobes.next_location;
    assign w_temp_next_location_enable  = strobes.temp_next_location;
    assign w_epsilon_register_enable    = strobes.epsilon_register;
    assign w_epsilon_threshhold_enable  = strobes.epsilon_threshold;
    assign remember_mode                = strobes.remember_mode;
    assign naddr_enviroment_register_en = strobes.naddr_environment;
    assign w_curent_location_select     = strobes.current_location_select;
    assign w_g_register_select          = strobes.g_register_select;
    assign w_step_count_select          = strobes.step_count_select;
    assign equal_select                 = strobes.equal_select;
    assign w_qtable_en                  = strobes.w_qtable_en;
    assign tx_dv                        = strobes.tx_dv;
    assign tx_sel                       = strobes.tx_sel;
    assign tx_data                      = strobes.tx_data;

endmodule

`default_nettype wire

// ==== logic/datapath_strobe_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath_strobe_decoder
    import dynaq_state_pkg::*;
    import dynaq_io_pkg::*;
(
    input  train_state_t      state,
    input  logic              step_freeze,
    input  logic              completed,
    output datapath_strobes_t strobes
);

    always_comb begin
        strobes         = '0;
        strobes.tx_data = TX_CODE_REPORT;   // Idle byte on the transmitter

        case (state)
            ST_INIT: begin
                strobes.update_episode     = 1'b1;
                strobes.next_location      = 1'b1;
                strobes.step_count         = !step_freeze;
                strobes.current_location   = 1'b1;
                strobes.temp_next_location = 1'b1;
                strobes.history_table      = 1'b1;
                strobes.history_table_2    = 1'b1;
            end
            ST_S1: begin
                strobes.qvalue                  = 1'b1;
                strobes.current_location        = completed;  // Reload start location
                strobes.current_location_select = 1'b1;
                strobes.equal_select            = 1'b1;
            end
            ST_S2: begin
                strobes.step_count              = !step_freeze;
                strobes.action_register         = 1'b1;
                strobes.epsilon_register        = 1'b1;
                strobes.current_location_select = 1'b1;
                strobes.step_count_select       = 1'b1;
                strobes.equal_select            = 1'b1;
            end
            ST_S3: begin
                strobes.reward_register         = 1'b1;
                strobes.naddr_environment       = 1'b1;
                strobes.next_location           = 1'b1;
                strobes.current_location_select = 1'b1;
            end
            ST_S4: begin
                strobes.qvalue                  = 1'b1;
                strobes.temp_next_location      = completed;
                strobes.epsilon_threshold       = !completed;  // Only while learning
                strobes.current_location_select = 1'b1;
            end
            ST_S5: begin
                strobes.max_register = 1'b1;
                strobes.equal_select = 1'b1;
            end
            ST_S6: begin
                strobes.g_register   = 1'b1;
                strobes.equal_select = 1'b1;
            end
            ST_S7: begin
                strobes.g_register              = 1'b1;
                strobes.temp_next_location      = 1'b1;
                strobes.current_location_select = 1'b1;
                strobes.g_register_select       = 1'b1;
            end
            ST_S8: begin
                strobes.current_location        = 1'b1;
                strobes.w_qtable_en             = 1'b1;
                strobes.current_location_select = 1'b1;
                strobes.equal_select            = 1'b1;
            end
            ST_S9: begin
                strobes.history_table_2         = 1'b1;
                strobes.remember_mode           = 1'b1;
                strobes.current_location_select = 1'b1;
                strobes.equal_select            = 1'b1;
            end
            ST_S10, ST_S11: begin
                strobes.qvalue                  = (state == ST_S10);
                strobes.remember_mode           = (state == ST_S10);
                strobes.max_register            = (state == ST_S11);
                strobes.current_location_select = 1'b1;
                strobes.step_count_select       = 1'b1;
                strobes.equal_select            = 1'b1;
            end
            ST_S12: begin
                strobes.g_register   = 1'b1;
                strobes.equal_select = 1'b1;
            end
            ST_S13: begin
                strobes.g_register              = 1'b1;
                strobes.remember_mode           = 1'b1;
                strobes.current_location_select = 1'b1;
                strobes.equal_select            = 1'b1;
                strobes.g_register_select       = 1'b1;
            end
            ST_S14: begin
                strobes.w_qtable_en             = 1'b1;
                strobes.history_table           = 1'b1;
                strobes.remember_mode           = 1'b1;
                strobes.current_location_select = 1'b1;
                strobes.g_register_select       = 1'b1;
            end
            ST_S15, ST_S16, ST_S17, ST_S18: begin
                strobes.current_location_select = 1'b1;
                strobes.step_count_select       = 1'b1;
                strobes.equal_select            = 1'b1;
                // Step end writes, report states drive the transmitter
                strobes.current_location = (state == ST_S15);
                strobes.w_qtable_en      = (state == ST_S15);
                strobes.history_table    = (state == ST_S15);
                strobes.tx_dv            = (state != ST_S15);
                strobes.tx_sel           = (state == ST_S17) || (state == ST_S18);
                if (state == ST_S17) begin
                    strobes.tx_data = TX_CODE_DONE;
                end
            end
            default: begin
                // ST_DECISION and unused codes keep everything low
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/training_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module training_sequencer
    import dynaq_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic         next,
    input  logic         completed,
    input  logic         done,
    input  logic         remember_en,
    input  logic         tx_done,
    output train_state_t state,
    output logic         step_freeze
);

    train_state_t next_state;
    logic         done_flag;   // Episode finished, seen at step end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= RESET_STATE;
        end else begin
            state <= next_state;
        end
    end

    // Cleared every step in S4, reloaded from done in S15
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            done_flag <= 1'b0;
        end else if (state == ST_S4) begin
            done_flag <= 1'b0;
        end else if (state == ST_S15) begin
            done_flag <= done;
        end
    end

    // Once training is complete the step counter stops for good
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_freeze <= 1'b0;
        end else if (state == ST_DECISION && completed) begin
            step_freeze <= 1'b1;
        end
    end

    always_comb begin
        case (state)
            ST_DECISION: begin
                if (!completed) begin
                    next_state = start ? ST_INIT : ST_DECISION;
                end else begin
                    next_state = !next ? ST_INIT : ST_DECISION;
                end
            end
            ST_INIT: next_state = ST_S1;
            ST_S1:   next_state = (completed && !next) ? ST_S1 : ST_S2;  // Hold for next
            ST_S2:   next_state = done ? ST_INIT : ST_S3;
            ST_S3:   next_state = ST_S4;
            ST_S4:   next_state = completed ? ST_S16 : ST_S5;
            ST_S5:   next_state = ST_S6;
            ST_S6:   next_state = ST_S7;
            ST_S7:   next_state = (remember_en || done) ? ST_S8 : ST_S15;
            ST_S8:   next_state = ST_S9;
            ST_S9:   next_state = ST_S10;
            ST_S10:  next_state = ST_S11;
            ST_S11:  next_state = ST_S12;
            ST_S12:  next_state = ST_S13;
            ST_S13:  next_state = ST_S14;
            ST_S14: begin
                if (!done_flag) begin
                    next_state = ST_S1;
                end else begin
                    next_state = completed ? ST_DECISION : ST_INIT;
                end
            end
            ST_S15:  next_state = done_flag ? ST_INIT : ST_S1;
            ST_S16:  next_state = tx_done ? ST_S17 : ST_S16;  // Wait on transmitter
            ST_S17:  next_state = tx_done ? ST_S18 : ST_S17;
            ST_S18: begin
                if (!tx_done) begin
                    next_state = ST_S18;
                end else begin
                    next_state = done_flag ? ST_DECISION : ST_S1;
                end
            end
            default: next_state = ST_INIT;   // Unused codes
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/dynaq_io_pkg.sv ====
`default_nettype none

package dynaq_io_pkg;

    localparam int TX_BYTE_W = 8;

    // Report bytes sent to the serial transmitter
    localparam logic [TX_BYTE_W-1:0] TX_CODE_REPORT = 8'h0A;
    localparam logic [TX_BYTE_W-1:0] TX_CODE_DONE   = 8'h0D;

    // Everything the controller drives towards the Q-learning datapath
    typedef struct packed {
        // Register write enables
        logic                 update_episode;
        logic                 history_table;
        logic                 history_table_2;
        logic                 g_register;
        logic                 max_register;
        logic                 reward_register;
        logic                 qvalue;
        logic                 step_count;
        logic                 action_register;
        logic                 current_location;
        logic                 next_location;
        logic                 temp_next_location;
        logic                 epsilon_register;
        logic                 epsilon_threshold;
        logic                 remember_mode;       // Replay addressing
        logic                 naddr_environment;
        // Datapath mux selects
        logic                 current_location_select;
        logic                 g_register_select;
        logic                 step_count_select;
        logic                 equal_select;
        // Q table write port
        logic                 w_qtable_en;
        // Transmitter side
        logic                 tx_dv;
        logic                 tx_sel;
        logic [TX_BYTE_W-1:0] tx_data;
    } datapath_strobes_t;

endpackage

`default_nettype wire

// ==== logic/dynaq_state_pkg.sv ====
`default_nettype none

package dynaq_state_pkg;

    localparam int STATE_W    = 5;
    localparam int NUM_STATES = 20;

    // Training sequence states, codes match the datapath documentation
    typedef enum logic [STATE_W-1:0] {
        ST_INIT     = 5'd0,   // Episode start
        ST_S1       = 5'd1,   // Action choice
        ST_S2       = 5'd2,
        ST_S3       = 5'd3,   // Reward and next location
        ST_S4       = 5'd4,
        ST_S5       = 5'd5,   // Max-Q
        ST_S6       = 5'd6,
        ST_S7       = 5'd7,   // Q update, branch to replay
        ST_S8       = 5'd8,   // Replay pass S8..S14
        ST_S9       = 5'd9,
        ST_S10      = 5'd10,
        ST_S11      = 5'd11,
        ST_S12      = 5'd12,
        ST_S13      = 5'd13,
        ST_S14      = 5'd14,
        ST_S15      = 5'd15,  // Step end
        ST_S16      = 5'd16,  // Report bytes S16..S18
        ST_S17      = 5'd17,
        ST_S18      = 5'd18,
        ST_DECISION = 5'd19   // Idle until start
    } train_state_t;

    localparam train_state_t RESET_STATE = ST_DECISION;

endpackage

`default_nettype wire
